/* bench/enqueue_tests.svh */
`ifndef ENQUEUE_TESTS_SVH
`define ENQUEUE_TESTS_SVH

// columns: source field, destination field, drop bit, tpifo_valid,
// buffer almost full mask, pifo full mask, beats (two or more)
typedef struct packed
{
    logic [7:0]  src;
    logic [7:0]  dst;
    logic        drop_bit;
    logic        pifo_valid;
    queue_mask_t almost_full;
    queue_mask_t pifo_full;
    logic [7:0]  beats;
} pkt_case_t;

localparam int num_cases = 11;

localparam pkt_case_t pkt_cases [num_cases] = '{
    '{8'h01, 8'h04, 1'b0, 1'b1, 5'b00000, 5'b00000, 8'd2},  // unicast nf0 to nf1
    '{8'h04, 8'h01, 1'b0, 1'b1, 5'b00000, 5'b00000, 8'd5},
    '{8'h10, 8'h57, 1'b0, 1'b1, 5'b00010, 5'b01000, 8'd4},  // multicast with dma, two full
    '{8'h40, 8'hA1, 1'b0, 1'b1, 5'b00000, 5'b00001, 8'd3},  // only the dma queue left
    '{8'h01, 8'h14, 1'b1, 1'b1, 5'b00000, 5'b00000, 8'd3},  // drop bit
    '{8'h10, 8'h05, 1'b0, 1'b1, 5'b00001, 5'b00010, 8'd2},  // every destination full
    '{8'h02, 8'h40, 1'b0, 1'b0, 5'b00000, 5'b00000, 8'd4},  // no pifo entry, dma source
    '{8'h01, 8'h14, 1'b1, 1'b1, 5'b00000, 5'b00000, 8'd2},
    '{8'h00, 8'h02, 1'b0, 1'b1, 5'b00000, 5'b10000, 8'd3},  // unmatched source
    '{8'h05, 8'h10, 1'b0, 1'b1, 5'b00000, 5'b00000, 8'd2},
    '{8'h04, 8'hFF, 1'b1, 1'b1, 5'b00000, 5'b00000, 8'd2}
};

`endif

/* bench/tb_enqueue_agent.sv */
module tb_enqueue_agent;

    timeunit 1ns;
    timeprecision 1ps;

    import enqueue_pkg::*;

    `include "enqueue_tests.svh"

    localparam int counter_width = 32;

    logic                       axis_aclk = 1'b0;
    logic                       axis_resetn;
    logic                       s_axis_tvalid;
    logic                       s_axis_tready;
    logic [tuser_width-1:0]     s_axis_tuser;
    logic                       s_axis_tlast;
    logic                       s_axis_tpifo_valid;
    queue_mask_t                buffer_almost_full;
    queue_mask_t                pifo_full;
    queue_mask_t                ctl_pifo_in_en;
    queue_mask_t                ctl_buffer_wr_en;
    logic                       cpu_read_req;
    logic [addr_width-1:0]      cpu_read_addr;
    logic [counter_width-1:0]   cpu_read_data;
    logic                       cpu_read_valid;

    // expected drop counts per [source][destination]
    logic [counter_width-1:0]   exp_cnt [queue_num][queue_num];

    integer seed = 32'hf37dd80d;
    int     checks = 0;
    int     mask_errors = 0;
    int     count_errors = 0;
    int     bit_errors = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    enqueue_agent #(.counter_width(counter_width)) UUT
    (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tready      (s_axis_tready),
        .s_axis_tuser       (s_axis_tuser),
        .s_axis_tlast       (s_axis_tlast),
        .s_axis_tpifo_valid (s_axis_tpifo_valid),
        .buffer_almost_full (buffer_almost_full),
        .pifo_full          (pifo_full),
        .ctl_pifo_in_en     (ctl_pifo_in_en),
        .ctl_buffer_wr_en   (ctl_buffer_wr_en),
        .cpu_read_req       (cpu_read_req),
        .cpu_read_addr      (cpu_read_addr),
        .cpu_read_data      (cpu_read_data),
        .cpu_read_valid     (cpu_read_valid)
    );

    always #50 axis_aclk = ~axis_aclk;

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_mask(input string name, input queue_mask_t got, input queue_mask_t exp);
        checks++;
        if (got !== exp)
        begin
            mask_errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input logic [counter_width-1:0] got,
                               input logic [counter_width-1:0] exp);
        checks++;
        if (got !== exp)
        begin
            count_errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            bit_errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic print_counts();
        $display("checks %0d, mask errors %0d, count errors %0d, bit errors %0d",
                 checks, mask_errors, count_errors, bit_errors);
    endtask

    ////////////////////////////////////////
    // reference rules
    ////////////////////////////////////////

    // nf port q sits on bit 2q and the odd bits are dma
    function automatic queue_mask_t fold_dst(input logic [7:0] dst);
        queue_mask_t m;
        for (int q = 0; q < 4; q++)
            m[q] = dst[2*q];
        m[4] = |(dst & 8'hAA);
        return m;
    endfunction

    function automatic queue_idx_t source_index(input logic [7:0] src);
        for (int q = 0; q < 4; q++)
        begin
            if (src == (8'h01 << (2*q)))
                return queue_idx_t'(q);
        end
        return cpu_queue;
    endfunction

    function automatic queue_idx_t clamp_nibble(input logic [3:0] n);
        if (n > 4'd4)
            return cpu_queue;
        return n[2:0];
    endfunction

    function automatic logic [tuser_width-1:0] random_tuser();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    ////////////////////////////////////////
    // packet and read sequences
    ////////////////////////////////////////

    task automatic play_packet(input pkt_case_t pc);
        queue_mask_t            dmask;
        queue_mask_t            rmask;
        queue_idx_t             sidx;
        logic                   dropped;
        queue_mask_t            exp_pifo;
        queue_mask_t            exp_buf;
        logic                   exp_ready;
        logic                   accepted;
        logic [tuser_width-1:0] hdr;
        int                     beat;
        int                     edges;
        logic                   done;

        dmask = fold_dst(pc.dst);
        rmask = dmask & ~pc.almost_full & ~pc.pifo_full;
        sidx = source_index(pc.src);
        dropped = pc.drop_bit || (rmask == '0) || !pc.pifo_valid;
        exp_pifo = '0;
        exp_buf = '0;
        exp_ready = 1'b0;
        beat = 0;
        edges = 0;
        done = 1'b0;

        hdr = random_tuser();
        hdr[src_pos +: 8] = pc.src;
        hdr[dst_pos +: 8] = pc.dst;
        hdr[drop_pos] = pc.drop_bit;

        @(posedge axis_aclk);
        s_axis_tvalid      <= 1'b1;
        s_axis_tuser       <= hdr;
        s_axis_tlast       <= 1'b0;
        s_axis_tpifo_valid <= pc.pifo_valid;
        buffer_almost_full <= pc.almost_full;
        pifo_full          <= pc.pifo_full;

        while (!done)
        begin
            @(negedge axis_aclk);
            check_bit("s_axis_tready", s_axis_tready, exp_ready);
            check_mask("ctl_pifo_in_en", ctl_pifo_in_en, exp_pifo);
            check_mask("ctl_buffer_wr_en", ctl_buffer_wr_en, exp_buf);
            accepted = s_axis_tvalid && s_axis_tready;
            @(posedge axis_aclk);
            edges++;
            exp_pifo = '0;
            // agent saw tvalid in idle on this edge
            if (edges == 1)
            begin
                exp_ready = 1'b1;
                if (dropped)
                begin
                    for (int d = 0; d < queue_num; d++)
                    begin
                        if (dmask[d])
                            exp_cnt[sidx][d] = exp_cnt[sidx][d] + 1'b1;
                    end
                end
            end
            if (accepted)
            begin
                if (beat == 0 && !dropped)
                begin
                    exp_pifo = rmask;
                    exp_buf = rmask;
                end
                beat++;
                if (beat == int'(pc.beats))
                begin
                    exp_ready = 1'b0;
                    exp_buf = '0;
                    done = 1'b1;
                    s_axis_tvalid <= 1'b0;
                    s_axis_tlast  <= 1'b0;
                end
                else
                begin
                    s_axis_tuser <= random_tuser();
                    s_axis_tlast <= (beat == int'(pc.beats) - 1);
                end
            end
        end

        @(negedge axis_aclk);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_mask("ctl_pifo_in_en", ctl_pifo_in_en, '0);
        check_mask("ctl_buffer_wr_en", ctl_buffer_wr_en, '0);
        check_bit("fsm in idle", UUT.u_enqueue_fsm.state == idle, 1'b1);
    endtask

    task automatic read_counter(input logic [addr_width-1:0] addr);
        logic [counter_width-1:0] exp;

        exp = exp_cnt[clamp_nibble(addr[7:4])][clamp_nibble(addr[3:0])];
        @(posedge axis_aclk);
        cpu_read_req  <= 1'b1;
        cpu_read_addr <= addr;
        @(negedge axis_aclk);
        check_bit("cpu_read_valid", cpu_read_valid, 1'b0);
        @(posedge axis_aclk);
        cpu_read_req <= 1'b0;
        @(negedge axis_aclk);
        check_bit("cpu_read_valid", cpu_read_valid, 1'b1);
        check_count($sformatf("cpu_read_data[0x%0h]", addr), cpu_read_data, exp);
        @(negedge axis_aclk);
        check_bit("cpu_read_valid", cpu_read_valid, 1'b0);
    endtask

    task automatic read_all_counters();
        for (int s = 0; s < queue_num; s++)
        begin
            for (int d = 0; d < queue_num; d++)
                read_counter({4'(s), 4'(d)});
        end
    endtask

    ////////////////////////////////////////
    // run limit
    ////////////////////////////////////////

    always @(posedge axis_aclk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            print_counts();
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        axis_resetn        = 1'b0;
        s_axis_tvalid      = 1'b0;
        s_axis_tuser       = '0;
        s_axis_tlast       = 1'b0;
        s_axis_tpifo_valid = 1'b0;
        buffer_almost_full = '0;
        pifo_full          = '0;
        cpu_read_req       = 1'b0;
        cpu_read_addr      = '0;
        for (int s = 0; s < queue_num; s++)
        begin
            for (int d = 0; d < queue_num; d++)
                exp_cnt[s][d] = '0;
        end
        for (int i = 0; i < num_cases; i++)
            cycle_limit = cycle_limit + int'(pkt_cases[i].beats) * 4;
        cycle_limit = cycle_limit + 200;

        repeat (8) @(posedge axis_aclk);
        axis_resetn <= 1'b1;

        @(negedge axis_aclk);
        check_bit("s_axis_tready", s_axis_tready, 1'b0);
        check_mask("ctl_pifo_in_en", ctl_pifo_in_en, '0);
        check_mask("ctl_buffer_wr_en", ctl_buffer_wr_en, '0);
        check_bit("cpu_read_valid", cpu_read_valid, 1'b0);
        check_count("cpu_read_data", cpu_read_data, '0);
        read_all_counters();

        for (int i = 0; i < num_cases; i++)
            play_packet(pkt_cases[i]);

        read_all_counters();
        // nibbles past queue 4 land on queue 4
        read_counter(8'hA3);
        read_counter(8'h0A);
        read_counter(8'hB9);

        print_counts();
        if (mask_errors + count_errors + bit_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+bench
source/enqueue_pkg.sv
source/port_decode.sv
source/enqueue_fsm.sv
source/drop_counter_bank.sv
source/enqueue_agent.sv
bench/tb_enqueue_agent.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_enqueue_agent -f filelist.f \
    -o sim_enqueue_agent \
    && ./obj_dir/sim_enqueue_agent > sim.log \
    || { echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1 || exit 0

/* source/drop_counter_bank.sv */
module drop_counter_bank
#(
    parameter int counter_width = 32
)
(
    input  logic                               axis_aclk,
    input  logic                               axis_resetn,
    input  logic                               count_en,
    input  enqueue_pkg::queue_idx_t            src_idx,
    input  enqueue_pkg::queue_mask_t           dst_mask,
    input  logic                               read_req,
    input  logic [enqueue_pkg::addr_width-1:0] read_addr,
    output logic [counter_width-1:0]           read_data,
    output logic                               read_valid
);

    import enqueue_pkg::*;

    localparam int nibble_width = addr_width / 2;

    // drop_cnt[s][d] counts drops from source s towards destination d
    logic [counter_width-1:0] drop_cnt [queue_num][queue_num];

    logic [nibble_width-1:0] src_nib;
    logic [nibble_width-1:0] dst_nib;
    queue_idx_t              src_sel;
    queue_idx_t              dst_sel;

    ////////////////////////////////////////
    // address decode
    ////////////////////////////////////////

    assign src_nib = read_addr[addr_width-1 -: nibble_width];
    assign dst_nib = read_addr[nibble_width-1:0];

    // anything past the last nf queue reads the cpu queue
    always_comb
    begin
        if (src_nib >= queue_num)
            src_sel = cpu_queue;
        else
            src_sel = queue_idx_t'(src_nib);

        if (dst_nib >= queue_num)
            dst_sel = cpu_queue;
        else
            dst_sel = queue_idx_t'(dst_nib);
    end

    ////////////////////////////////////////
    // counters
    ////////////////////////////////////////

    // one row per packet, a bit per destination, wraps on overflow
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int s = 0; s < queue_num; s++)
            begin
                for (int d = 0; d < queue_num; d++)
                begin
                    drop_cnt[s][d] <= '0;
                end
            end
        end
        else
        begin
            for (int d = 0; d < queue_num; d++)
            begin
                if (count_en && dst_mask[d])
                    drop_cnt[src_idx][d] <= drop_cnt[src_idx][d] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // read response
    ////////////////////////////////////////

    // value before any same-cycle increment
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            read_data  <= '0;
            read_valid <= 1'b0;
        end
        else
        begin
            read_valid <= read_req;
            if (read_req)
                read_data <= drop_cnt[src_sel][dst_sel];
        end
    end

    // response comes exactly one cycle after the strobe
    read_latency: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (read_req |=> read_valid) and (!read_req |=> !read_valid)
    );

endmodule

/* source/enqueue_agent.sv */
module enqueue_agent
#(
    parameter int counter_width = 32
)
(
    input  logic                                axis_aclk,
    input  logic                                axis_resetn,

    // packet stream from the pipeline
    input  logic                                s_axis_tvalid,
    output logic                                s_axis_tready,
    input  logic [enqueue_pkg::tuser_width-1:0] s_axis_tuser,
    input  logic                                s_axis_tlast,
    input  logic                                s_axis_tpifo_valid,

    // queue status
    input  enqueue_pkg::queue_mask_t            buffer_almost_full,
    input  enqueue_pkg::queue_mask_t            pifo_full,

    // per-queue controls
    output enqueue_pkg::queue_mask_t            ctl_pifo_in_en,
    output enqueue_pkg::queue_mask_t            ctl_buffer_wr_en,

    // drop counter access
    input  logic                                cpu_read_req,
    input  logic [enqueue_pkg::addr_width-1:0]  cpu_read_addr,
    output logic [counter_width-1:0]            cpu_read_data,
    output logic                                cpu_read_valid
);

    import enqueue_pkg::*;

    queue_mask_t dst_mask;
    queue_mask_t ready_mask;
    queue_idx_t  src_idx;
    logic        drop_flag;
    logic        count_en;

    ////////////////////////////////////////
    // metadata decode
    ////////////////////////////////////////

    port_decode u_port_decode
    (
        .tuser              (s_axis_tuser),
        .buffer_almost_full (buffer_almost_full),
        .pifo_full          (pifo_full),
        .dst_mask           (dst_mask),
        .ready_mask         (ready_mask),
        .src_idx            (src_idx),
        .drop_flag          (drop_flag)
    );

    ////////////////////////////////////////
    // packet control
    ////////////////////////////////////////

    enqueue_fsm u_enqueue_fsm
    (
        .axis_aclk    (axis_aclk),
        .axis_resetn  (axis_resetn),
        .tvalid       (s_axis_tvalid),
        .tlast        (s_axis_tlast),
        .tpifo_valid  (s_axis_tpifo_valid),
        .drop_flag    (drop_flag),
        .ready_mask   (ready_mask),
        .tready       (s_axis_tready),
        .pifo_in_en   (ctl_pifo_in_en),
        .buffer_wr_en (ctl_buffer_wr_en),
        .count_en     (count_en)
    );

    ////////////////////////////////////////
    // drop statistics
    ////////////////////////////////////////

    drop_counter_bank
    #(
        .counter_width (counter_width)
    )
    u_drop_counter_bank
    (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .count_en    (count_en),
        .src_idx     (src_idx),
        .dst_mask    (dst_mask),
        .read_req    (cpu_read_req),
        .read_addr   (cpu_read_addr),
        .read_data   (cpu_read_data),
        .read_valid  (cpu_read_valid)
    );

endmodule

/* source/enqueue_fsm.sv */
module enqueue_fsm
(
    input  logic                     axis_aclk,
    input  logic                     axis_resetn,
    input  logic                     tvalid,
    input  logic                     tlast,
    input  logic                     tpifo_valid,
    input  logic                     drop_flag,
    input  enqueue_pkg::queue_mask_t ready_mask,
    output logic                     tready,
    output enqueue_pkg::queue_mask_t pifo_in_en,
    output enqueue_pkg::queue_mask_t buffer_wr_en,
    output logic                     count_en
);

    import enqueue_pkg::*;

    eq_state_t   state;
    eq_state_t   state_next;
    logic        tready_next;
    queue_mask_t pifo_en_next;
    queue_mask_t wr_en_next;
    logic        drop_pkt;
    logic        last_beat;

    // drop on request, when nothing has room, or without a pifo entry
    assign drop_pkt = drop_flag || (ready_mask == '0) || !tpifo_valid;

    assign last_beat = tvalid && tready && tlast;

    // single pulse, idle is left on the next edge
    assign count_en = (state == idle) && tvalid && drop_pkt;

    ////////////////////////////////////////
    // next state
    ////////////////////////////////////////

    always_comb
    begin
        state_next   = state;
        tready_next  = 1'b0;
        pifo_en_next = pifo_in_en;
        wr_en_next   = buffer_wr_en;

        case (state)
            idle:
            begin
                pifo_en_next = '0;
                wr_en_next   = '0;
                if (tvalid)
                begin
                    tready_next = 1'b1;
                    if (drop_pkt)
                        state_next = drop;
                    else
                        state_next = enqueue_sop;
                end
            end

            // header beat on the bus, open the queues that have room
            enqueue_sop:
            begin
                tready_next  = 1'b1;
                pifo_en_next = ready_mask;
                wr_en_next   = ready_mask;
                state_next   = enqueue_remain;
            end

            enqueue_remain:
            begin
                // one pifo entry per packet
                pifo_en_next = '0;
                if (last_beat)
                begin
                    wr_en_next = '0;
                    state_next = idle;
                end
                else
                begin
                    tready_next = 1'b1;
                end
            end

            // swallow beats up to eop
            drop:
            begin
                if (last_beat)
                    state_next = idle;
                else
                    tready_next = 1'b1;
            end
        endcase
    end

    ////////////////////////////////////////
    // registers
    ////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state        <= idle;
            tready       <= 1'b0;
            pifo_in_en   <= '0;
            buffer_wr_en <= '0;
        end
        else
        begin
            state        <= state_next;
            tready       <= tready_next;
            pifo_in_en   <= pifo_en_next;
            buffer_wr_en <= wr_en_next;
        end
    end

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // a packet writes the pifo once
    pifo_single_cycle: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (pifo_in_en != '0) |=> (pifo_in_en == '0)
    );

    // pifo entries only go with a buffer write
    pifo_within_buffer: assert property (
        @(posedge axis_aclk) disable iff (!axis_resetn)
        (pifo_in_en & ~buffer_wr_en) == '0
    );

endmodule

/* source/enqueue_pkg.sv */
package enqueue_pkg;

    ////////////////////////////////////////
    // queue set
    ////////////////////////////////////////

    // nf0 to nf3 plus the shared cpu/dma queue
    localparam int queue_num = 5;

    typedef logic [queue_num-1:0] queue_mask_t;
    typedef logic [2:0]           queue_idx_t;

    // every dma bit and any unmatched source lands here
    localparam queue_idx_t cpu_queue = 3'd4;

    ////////////////////////////////////////
    // metadata layout
    ////////////////////////////////////////

    localparam int tuser_width = 128;

    // one-hot fields, {dma, nf3, dma, nf2, dma, nf1, dma, nf0}
    localparam int src_pos = 16;
    localparam int dst_pos = 24;

    // only the lowest bit of the drop byte is looked at
    localparam int drop_pos = 32;

    ////////////////////////////////////////
    // cpu read port
    ////////////////////////////////////////

    // high nibble selects the source, low nibble the destination
    localparam int addr_width = 8;

    ////////////////////////////////////////
    // packet machine
    ////////////////////////////////////////

    typedef enum logic [1:0]
    {
        idle           = 2'd0,
        enqueue_sop    = 2'd1,
        enqueue_remain = 2'd2,
        drop           = 2'd3
    } eq_state_t;

endpackage

/* source/port_decode.sv */
module port_decode
(
    input  logic [enqueue_pkg::tuser_width-1:0] tuser,
    input  enqueue_pkg::queue_mask_t            buffer_almost_full,
    input  enqueue_pkg::queue_mask_t            pifo_full,
    output enqueue_pkg::queue_mask_t            dst_mask,
    output enqueue_pkg::queue_mask_t            ready_mask,
    output enqueue_pkg::queue_idx_t             src_idx,
    output logic                                drop_flag
);

    import enqueue_pkg::*;

    logic [7:0] src_field;
    logic [7:0] dst_field;

    assign src_field = tuser[src_pos +: 8];
    assign dst_field = tuser[dst_pos +: 8];

    ////////////////////////////////////////
    // destination folding
    ////////////////////////////////////////

    // even bits are the nf ports
    always_comb
    begin
        dst_mask = '0;
        for (int q = 0; q < 4; q++)
        begin
            dst_mask[q] = dst_field[2*q];
        end
        // odd bits all go to the cpu queue
        dst_mask[cpu_queue] = dst_field[1] | dst_field[3] | dst_field[5] | dst_field[7];
    end

    ////////////////////////////////////////
    // source index
    ////////////////////////////////////////

    // only a clean one-hot nf source gets its own index
    always_comb
    begin
        case (src_field)
            8'h01:   src_idx = 3'd0;
            8'h04:   src_idx = 3'd1;
            8'h10:   src_idx = 3'd2;
            8'h40:   src_idx = 3'd3;
            default: src_idx = cpu_queue;
        endcase
    end

    assign drop_flag = tuser[drop_pos];

    // queues that can take the packet right now
    assign ready_mask = dst_mask & ~buffer_almost_full & ~pifo_full;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // the counter bank indexes its rows with this
    always_comb
    begin
        src_idx_range: assert (src_idx <= cpu_queue)
        else
            $error("src_idx out of range: %0d", src_idx);
    end

endmodule
